/* include/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// width of the datapath, registers and byte addresses
`define XLEN 32

// x0 to x31
`define REG_ADDR_W 5

// data RAM size in 32-bit words addressed by word index
`define DRAM_WORDS 64

`endif

/* rtl/isa_pkg.sv */
package isa_pkg;

    // ALU operations selected by the decoder
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_slt    = 4'd8,
        alu_sltu   = 4'd9,
        alu_pass_b = 4'd10 // used by lui
    } alu_op_e;

    // next PC choice that the memory stage resolves
    typedef enum logic [2:0] {
        npc_plus4              = 3'd0,
        npc_branch_if_zero     = 3'd1,
        npc_branch_if_not_zero = 3'd2,
        npc_jal                = 3'd3,
        npc_jalr               = 3'd4
    } next_pc_src_e;

    typedef enum logic [1:0] {
        wb_alu      = 2'd0,
        wb_ram      = 2'd1,
        wb_pc_plus4 = 2'd2, // link address for jal and jalr
        wb_stdin    = 2'd3
    } wb_src_e;

endpackage

/* rtl/pipe_pkg.sv */
`include "rv_defines.svh"

package pipe_pkg;
    import isa_pkg::*;

    // ------------------------------
    // ID/EX bundle from decode
    // ------------------------------
    typedef struct packed {
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      rs1_data;
        logic [`XLEN-1:0]      rs2_data;
        logic [`XLEN-1:0]      imm;
        logic [`REG_ADDR_W-1:0] rd_address;
        alu_op_e               alu_op;
        logic                  use_imm;   // operand b is imm instead of rs2
        next_pc_src_e          next_pc_src;
        wb_src_e               reg_write_data_src;
        logic                  reg_write_enable;
        logic                  ram_read;
        logic                  ram_write_enable;
        logic                  stdin_read_enable;
        logic                  stdout_write_enable;
    } id_ex_t;

    // ------------------------------
    // EX/MEM bundle
    // ------------------------------
    typedef struct packed {
        logic [`XLEN-1:0]       pc_data;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data; // store data and stdout byte
        logic [`REG_ADDR_W-1:0] rd_address;
        logic [`XLEN-1:0]       alu_rd_result;
        logic                   alu_rd_result_is_zero;
        logic [`XLEN-1:0]       alu_pc_result;
        next_pc_src_e           next_pc_src;
        wb_src_e                reg_write_data_src;
        logic                   reg_write_enable;
        logic                   ram_read;
        logic                   ram_write_enable;
        logic                   stdin_read_enable;
        logic                   stdout_write_enable;
    } ex_mem_t;

    // write-back bundle leaving the memory stage
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd_address;
        logic                   reg_write_enable;
        logic [`XLEN-1:0]       write_data;
    } mem_wb_t;

endpackage

/* rtl/execute_unit.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module execute_unit (
    input  pipe_pkg::id_ex_t  id_ex,
    output pipe_pkg::ex_mem_t ex_result
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_result;
    logic             lt_signed;
    logic             lt_unsigned;

    assign op_a  = id_ex.rs1_data;
    assign op_b  = id_ex.use_imm ? id_ex.imm : id_ex.rs2_data;
    assign shamt = op_b[4:0]; // only the low five bits count for shifts

    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb begin
        case (id_ex.alu_op)
            alu_add:    alu_result = op_a + op_b;
            alu_sub:    alu_result = op_a - op_b;
            alu_and:    alu_result = op_a & op_b;
            alu_or:     alu_result = op_a | op_b;
            alu_xor:    alu_result = op_a ^ op_b;
            alu_sll:    alu_result = op_a << shamt;
            alu_srl:    alu_result = op_a >> shamt;
            alu_sra:    alu_result = $signed(op_a) >>> shamt;
            alu_slt:    alu_result = {{(`XLEN-1){1'b0}}, lt_signed};
            alu_sltu:   alu_result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            alu_pass_b: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // ------------------------------
    // bundle for the EX/MEM register
    // ------------------------------
    always_comb begin
        ex_result.pc_data               = id_ex.pc;
        ex_result.rs1_data              = id_ex.rs1_data;
        ex_result.rs2_data              = id_ex.rs2_data;
        ex_result.rd_address            = id_ex.rd_address;
        ex_result.alu_rd_result         = alu_result;
        ex_result.alu_rd_result_is_zero = (alu_result == '0); // beq and bne compare via sub

        // jalr jumps relative to rs1, everything else relative to pc
        if (id_ex.next_pc_src == npc_jalr) begin
            ex_result.alu_pc_result = id_ex.rs1_data + id_ex.imm;
        end else begin
            ex_result.alu_pc_result = id_ex.pc + id_ex.imm;
        end

        ex_result.next_pc_src         = id_ex.next_pc_src;
        ex_result.reg_write_data_src  = id_ex.reg_write_data_src;
        ex_result.reg_write_enable    = id_ex.reg_write_enable;
        ex_result.ram_read            = id_ex.ram_read;
        ex_result.ram_write_enable    = id_ex.ram_write_enable;
        ex_result.stdin_read_enable   = id_ex.stdin_read_enable;
        ex_result.stdout_write_enable = id_ex.stdout_write_enable;
    end

endmodule

/* rtl/ex_mem_pipeline_register.sv */
`timescale 1ns/1ps

module ex_mem_pipeline_register (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              write_enable,
    input  pipe_pkg::ex_mem_t in_bundle,
    output pipe_pkg::ex_mem_t bundle
);

    // a cleared bundle is a bubble with no writes, no port access and no branch
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            bundle <= '0;
        end else if (write_enable) begin
            bundle <= in_bundle;
        end
    end

endmodule

/* rtl/mem_stage.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module mem_stage (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              advance,
    input  pipe_pkg::ex_mem_t ex_mem,
    input  logic [7:0]        stdin_data,
    output pipe_pkg::mem_wb_t mem_wb,
    output logic              stdout_valid,
    output logic [7:0]        stdout_data,
    output logic              branch_taken,
    output logic [`XLEN-1:0]  branch_target
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int IDX_W = $clog2(`DRAM_WORDS);

    logic [`XLEN-1:0]      ram [`DRAM_WORDS];
    logic [`DRAM_WORDS-1:0] word_written; // unwritten words read as zero
    logic [IDX_W-1:0]      ram_index;
    logic [`XLEN-1:0]      ram_rdata;
    logic [7:0]            stdin_byte;
    logic [`XLEN-1:0]      wb_data;

    // the word index drops the byte offset and ignores the upper address bits
    assign ram_index = ex_mem.alu_rd_result[IDX_W+1:2];

    // ------------------------------
    // data RAM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (advance && ex_mem.ram_write_enable) begin
            ram[ram_index] <= ex_mem.rs2_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            word_written <= '0;
        end else if (advance && ex_mem.ram_write_enable) begin
            word_written[ram_index] <= 1'b1;
        end
    end

    assign ram_rdata  = (ex_mem.ram_read && word_written[ram_index]) ? ram[ram_index] : '0;
    assign stdin_byte = ex_mem.stdin_read_enable ? stdin_data : 8'h00;

    always_comb begin
        case (ex_mem.reg_write_data_src)
            wb_alu:      wb_data = ex_mem.alu_rd_result;
            wb_ram:      wb_data = ram_rdata;
            wb_pc_plus4: wb_data = ex_mem.pc_data + 4;
            wb_stdin:    wb_data = {{(`XLEN-8){1'b0}}, stdin_byte};
            default:     wb_data = ex_mem.alu_rd_result;
        endcase
    end

    // ------------------------------
    // MEM/WB register and console out
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            mem_wb       <= '0;
            stdout_valid <= 1'b0;
        end else begin
            stdout_valid <= advance && ex_mem.stdout_write_enable; // one pulse per instruction
            if (advance) begin
                mem_wb.rd_address       <= ex_mem.rd_address;
                mem_wb.reg_write_enable <= ex_mem.reg_write_enable;
                mem_wb.write_data       <= wb_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && ex_mem.stdout_write_enable) begin
            stdout_data <= ex_mem.rs2_data[7:0];
        end
    end

    // branch resolution is combinational from EX/MEM
    always_comb begin
        case (ex_mem.next_pc_src)
            npc_branch_if_zero:     branch_taken = ex_mem.alu_rd_result_is_zero;
            npc_branch_if_not_zero: branch_taken = !ex_mem.alu_rd_result_is_zero;
            npc_jal, npc_jalr:      branch_taken = 1'b1;
            default:                branch_taken = 1'b0;
        endcase
    end

    assign branch_target = ex_mem.alu_pc_result;

endmodule

/* rtl/ex_mem_top.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module ex_mem_top (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              advance,
    input  pipe_pkg::id_ex_t  id_ex,
    input  logic [7:0]        stdin_data,
    output pipe_pkg::mem_wb_t mem_wb,
    output logic              stdout_valid,
    output logic [7:0]        stdout_data,
    output logic              branch_taken,
    output logic [`XLEN-1:0]  branch_target
);
    import pipe_pkg::*;

    ex_mem_t ex_result; // combinational output of the execute stage
    ex_mem_t ex_mem;

    execute_unit execute_unit0 (
        .id_ex     (id_ex),
        .ex_result (ex_result)
    );

    ex_mem_pipeline_register ex_mem_reg0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .write_enable (advance),
        .in_bundle    (ex_result),
        .bundle       (ex_mem)
    );

    mem_stage mem_stage0 (
        .clk           (clk),
        .reset_n       (reset_n),
        .advance       (advance),
        .ex_mem        (ex_mem),
        .stdin_data    (stdin_data),
        .mem_wb        (mem_wb),
        .stdout_valid  (stdout_valid),
        .stdout_data   (stdout_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

endmodule

/* verif/ex_mem_checker.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module ex_mem_checker (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              advance,
    input  logic              in_valid,
    input  pipe_pkg::mem_wb_t exp_wb,
    input  logic              exp_taken,
    input  logic [`XLEN-1:0]  exp_target,
    input  logic              exp_out_valid,
    input  logic [7:0]        exp_out_byte,
    input  pipe_pkg::mem_wb_t mem_wb,
    input  logic              stdout_valid,
    input  logic [7:0]        stdout_data,
    input  logic              branch_taken,
    input  logic [`XLEN-1:0]  branch_target,
    output int                completed,
    output int                errors
);
    import pipe_pkg::*;

    typedef struct packed {
        mem_wb_t          wb;
        logic             taken;
        logic [`XLEN-1:0] target;
        logic             out_valid;
        logic [7:0]       out_byte;
    } expect_t;

    expect_t ex_q[$]; // instruction sitting in EX/MEM
    expect_t wb_q[$]; // result that MEM/WB shows at the next sample
    expect_t cur;
    expect_t entering;
    mem_wb_t last_wb;            // most recent result that reached MEM/WB
    logic    stalled = 1'b0;     // advance was low on the previous edge
    int      error_count = 0;
    int      done_count = 0;

    assign entering  = {exp_wb, exp_taken, exp_target, exp_out_valid, exp_out_byte};
    assign completed = done_count;
    assign errors    = error_count;

    task automatic compare_value(input string name, input logic [`XLEN-1:0] got,
                                 input logic [`XLEN-1:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                     $time, name, expected, got);
            error_count++;
        end
    endtask

    task automatic compare_wb(input mem_wb_t expected);
        compare_value("mem_wb.rd_address", 32'(mem_wb.rd_address), 32'(expected.rd_address));
        compare_value("mem_wb.reg_write_enable", 32'(mem_wb.reg_write_enable),
                      32'(expected.reg_write_enable));
        compare_value("mem_wb.write_data", mem_wb.write_data, expected.write_data);
    endtask

    // ------------------------------
    // sampled on the rising edge before the DUT registers update
    // ------------------------------
    always @(posedge clk) begin
        if (!reset_n) begin
            ex_q.delete();
            wb_q.delete();
            stalled = 1'b0;
        end else begin
            if (wb_q.size() != 0) begin
                cur = wb_q.pop_front();
                compare_wb(cur.wb);
                compare_value("stdout_valid", 32'(stdout_valid), 32'(cur.out_valid));
                if (cur.out_valid) begin
                    compare_value("stdout_data", 32'(stdout_data), 32'(cur.out_byte));
                end
                last_wb = cur.wb;
                done_count++;
            end else begin
                // nothing left MEM on the last edge and a pulse here would be a duplicate
                compare_value("stdout_valid", 32'(stdout_valid), 32'd0);
                if (done_count == 0) begin
                    compare_value("mem_wb.reg_write_enable", 32'(mem_wb.reg_write_enable),
                                  32'd0);
                end else if (stalled) begin
                    compare_wb(last_wb); // MEM/WB keeps its result through a stall
                end
            end

            if (ex_q.size() == 0) begin
                compare_value("branch_taken", 32'(branch_taken), 32'd0); // bubble in EX/MEM
            end

            if (advance) begin
                if (ex_q.size() != 0) begin
                    cur = ex_q.pop_front();
                    compare_value("branch_taken", 32'(branch_taken), 32'(cur.taken));
                    compare_value("branch_target", branch_target, cur.target);
                    wb_q.push_back(cur);
                end
                if (in_valid) begin
                    ex_q.push_back(entering);
                end
            end
            stalled = !advance;
        end
    end

endmodule

/* verif/tb_ex_mem.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_ex_mem;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int NUM_FIELDS  = 19;
    localparam int DRAIN_LIMIT = 40;

    logic             clk = 1'b0;
    logic             reset_n;
    logic             advance;
    id_ex_t           id_ex;
    logic [7:0]       stdin_data;
    mem_wb_t          mem_wb;
    logic             stdout_valid;
    logic [7:0]       stdout_data;
    logic             branch_taken;
    logic [`XLEN-1:0] branch_target;

    // expectation for the instruction on id_ex that the checker takes when it advances
    logic             in_valid;
    mem_wb_t          exp_wb;
    logic             exp_taken;
    logic [`XLEN-1:0] exp_target;
    logic             exp_out_valid;
    logic [7:0]       exp_out_byte;

    logic [31:0] field [NUM_FIELDS]; // one parsed golden line
    int          completed;
    int          check_errors;
    int          other_errors = 0;
    int          vectors = 0;
    logic [7:0]  pending_stdin = 8'h00;

    always #4 clk = ~clk;

    ex_mem_top dut0 (
        .clk           (clk),
        .reset_n       (reset_n),
        .advance       (advance),
        .id_ex         (id_ex),
        .stdin_data    (stdin_data),
        .mem_wb        (mem_wb),
        .stdout_valid  (stdout_valid),
        .stdout_data   (stdout_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    ex_mem_checker checker0 (
        .clk           (clk),
        .reset_n       (reset_n),
        .advance       (advance),
        .in_valid      (in_valid),
        .exp_wb        (exp_wb),
        .exp_taken     (exp_taken),
        .exp_target    (exp_target),
        .exp_out_valid (exp_out_valid),
        .exp_out_byte  (exp_out_byte),
        .mem_wb        (mem_wb),
        .stdout_valid  (stdout_valid),
        .stdout_data   (stdout_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .completed     (completed),
        .errors        (check_errors)
    );

    task automatic drive_bubble(input logic adv);
        id_ex         = '0;
        advance       = adv;
        stdin_data    = pending_stdin;
        in_valid      = 1'b0;
        exp_wb        = '0;
        exp_taken     = 1'b0;
        exp_target    = '0;
        exp_out_valid = 1'b0;
        exp_out_byte  = 8'h00;
    endtask

    task automatic run_vector();
        int stalls;
        @(negedge clk);
        id_ex.pc                  = field[0];
        id_ex.rs1_data            = field[1];
        id_ex.rs2_data            = field[2];
        id_ex.imm                 = field[3];
        id_ex.rd_address          = field[4][`REG_ADDR_W-1:0];
        id_ex.alu_op              = alu_op_e'(field[5][3:0]);
        id_ex.use_imm             = field[6][0];
        id_ex.next_pc_src         = next_pc_src_e'(field[7][2:0]);
        id_ex.reg_write_data_src  = wb_src_e'(field[8][1:0]);
        id_ex.reg_write_enable    = field[9][0];
        id_ex.ram_read            = field[10][0];
        id_ex.ram_write_enable    = field[11][0];
        id_ex.stdin_read_enable   = field[12][0];
        id_ex.stdout_write_enable = field[13][0];
        advance  = 1'b1;
        in_valid = 1'b1;
        // stdin is read in the memory stage and lags its instruction by one advance
        stdin_data    = pending_stdin;
        pending_stdin = field[14][7:0];
        exp_wb.rd_address       = field[4][`REG_ADDR_W-1:0];
        exp_wb.reg_write_enable = field[9][0];
        exp_wb.write_data       = field[15];
        exp_taken     = field[16][0];
        exp_target    = field[17];
        exp_out_valid = field[13][0];
        exp_out_byte  = field[18][7:0];
        vectors++;
        stalls = int'($urandom % 3);
        if (field[13][0] && stalls == 0) begin
            stalls = 1; // a stdout instruction always waits in EX/MEM through a stall
        end
        for (int i = 0; i < stalls; i++) begin
            @(negedge clk);
            advance = 1'b0; // everything else holds
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    wait_cycles;
        string line;

        void'($urandom(32'hcb2f));
        reset_n = 1'b0;
        drive_bubble(1'b0);
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        reset_n = 1'b1;

        fd = $fopen("verif/ex_mem_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/ex_mem_golden.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                field[0], field[1], field[2], field[3], field[4], field[5],
                                field[6], field[7], field[8], field[9], field[10], field[11],
                                field[12], field[13], field[14], field[15], field[16],
                                field[17], field[18]);
                    if (n == NUM_FIELDS) begin
                        run_vector();
                    end else begin
                        $display("golden line has %0d fields instead of %0d: %s",
                                 n, NUM_FIELDS, line);
                        other_errors++;
                    end
                end
            end
            $fclose(fd);
        end

        // ------------------------------
        // drain the pipeline with bubbles
        // ------------------------------
        wait_cycles = 0;
        while (completed < vectors && wait_cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            drive_bubble(1'b1);
            wait_cycles++;
        end
        repeat (4) @(negedge clk); // a late or doubled stdout pulse still gets sampled
        if (completed < vectors) begin
            $display("timeout: only %0d of %0d instructions reached write-back",
                     completed, vectors);
            other_errors++;
        end

        $display("vectors %0d, write-backs checked %0d, check errors %0d, other errors %0d",
                 vectors, completed, check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0 && vectors > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* verif/ex_mem_golden.txt */
# stimulus: pc rs1 rs2 imm rd alu_op use_imm next_pc_src wb_src reg_we ram_rd ram_we stdin_re stdout_we stdin
# expected: write_data branch_taken branch_target stdout_byte (every column in hex)
00000100 00000005 00000007 00000000 01 0 0 0 0 1 0 0 0 0 00 0000000c 0 00000100 00
00000104 00000010 00000000 fffffffc 02 0 1 0 0 1 0 0 0 0 00 0000000c 0 00000100 00
00000108 00000003 00000005 00000000 03 1 0 0 0 1 0 0 0 0 00 fffffffe 0 00000108 00
0000010c f0f0f0f0 ff00ff00 00000000 04 2 0 0 0 1 0 0 0 0 00 f000f000 0 0000010c 00
00000110 12340000 00000000 00005678 05 3 1 0 0 1 0 0 0 0 00 12345678 0 00005788 00
00000114 aaaaaaaa ffffffff 00000000 06 4 0 0 0 1 0 0 0 0 00 55555555 0 00000114 00
00000118 00000001 00000000 00000023 07 5 1 0 0 1 0 0 0 0 00 00000008 0 0000013b 00
0000011c 80000000 00000004 00000000 08 6 0 0 0 1 0 0 0 0 00 08000000 0 0000011c 00
00000120 80000000 00000000 00000004 09 7 1 0 0 1 0 0 0 0 00 f8000000 0 00000124 00
00000124 ffffffff 00000001 00000000 0a 8 0 0 0 1 0 0 0 0 00 00000001 0 00000124 00
00000128 ffffffff 00000001 00000000 0b 9 0 0 0 1 0 0 0 0 00 00000000 0 00000128 00
0000012c 00000000 00000000 12345000 0c a 1 0 0 1 0 0 0 0 00 12345000 0 1234512c 00
00000130 00000009 00000009 00000040 00 1 0 1 0 0 0 0 0 0 00 00000000 1 00000170 00
00000134 00000009 00000008 00000040 00 1 0 1 0 0 0 0 0 0 00 00000001 0 00000174 00
00000138 00000009 00000008 fffffff0 00 1 0 2 0 0 0 0 0 0 00 00000001 1 00000128 00
0000013c 00000007 00000007 fffffff0 00 1 0 2 0 0 0 0 0 0 00 00000000 0 0000012c 00
00000140 00000000 00000000 00000100 01 0 1 3 2 1 0 0 0 0 00 00000144 1 00000240 00
00000144 00001000 00000000 00000010 01 0 1 4 2 1 0 0 0 0 00 00000148 1 00001010 00
00000148 00000020 deadbeef 00000004 00 0 1 0 0 0 0 1 0 0 00 00000024 0 0000014c 00
0000014c 00000020 00000000 00000004 0d 0 1 0 1 1 1 0 0 0 00 deadbeef 0 00000150 00
00000150 00000080 00000000 00000000 0e 0 1 0 1 1 1 0 0 0 00 00000000 0 00000150 00
00000154 00000100 0badf00d 00000000 00 0 1 0 0 0 0 1 0 0 00 00000100 0 00000154 00
00000158 00000000 00000000 00000000 12 0 1 0 1 1 1 0 0 0 00 0badf00d 0 00000158 00
0000015c 00000000 00000141 00000000 00 0 0 0 0 0 0 0 0 1 00 00000141 0 0000015c 41
00000160 00000000 123456ff 00000000 00 0 0 0 0 0 0 0 0 1 00 123456ff 0 00000160 ff
00000164 00000000 00000000 00000000 0f 0 0 0 3 1 0 0 1 0 5a 0000005a 0 00000164 00
00000168 00000000 00000000 00000000 10 0 0 0 3 1 0 0 1 0 c3 000000c3 0 00000168 00
0000016c ffffffff 00000001 00000000 11 0 0 0 0 1 0 0 0 0 00 00000000 0 0000016c 00

/* flist.f */
+incdir+include
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/execute_unit.sv
rtl/ex_mem_pipeline_register.sv
rtl/mem_stage.sv
rtl/ex_mem_top.sv
verif/ex_mem_checker.sv
verif/tb_ex_mem.sv

/* Makefile */
TOP := tb_ex_mem

.PHONY: sim clean

# the run passes only when the testbench prints the pass message
sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "all tests passed"

clean:
	rm -rf obj_dir
